// File: design/ddr_link_pkg.sv
/* Shared APB and link control types for the DDR receive link.
   The register map assumes at most 32 channels in the STATUS word */
package ddr_link_pkg;

  // APB data width, also the width of every register
  localparam int APB_DATA_W = 32;

  // Register map
  localparam logic [7:0] CTRL_ADDR      = 8'h00;
  localparam logic [7:0] STATUS_ADDR    = 8'h04;
  localparam logic [7:0] PKT_COUNT_ADDR = 8'h08;

  // Requester side of APB
  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [7:0]            paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  // Completer side of APB
  typedef struct packed {
    logic                  pready;
    logic                  pslverr;
    logic [APB_DATA_W-1:0] prdata;
  } apb_rsp_t;

  // Control broadcast from the register block to every channel
  typedef struct packed {
    logic enable;
    // One-cycle pulse, empties the FIFOs and token counters
    logic flush;
  } link_ctrl_t;

endpackage

// File: design/link_ctrl_regs.sv
/* APB register block; pready is tied high, so every access takes two cycles.
   Unmapped addresses answer with pslverr and read as zero */
module link_ctrl_regs #(
  parameter int num_channel_p = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  ddr_link_pkg::apb_req_t    apb_req_i,
  output ddr_link_pkg::apb_rsp_t    apb_rsp_o,
  input  logic [num_channel_p-1:0]  overflow_i,
  input  logic                      pkt_accept_i,
  output ddr_link_pkg::link_ctrl_t  ctrl_o,
  output logic                      link_enable_o
);

  logic                                enable_r;
  logic                                flush_r;
  logic [num_channel_p-1:0]            overflow_r;
  logic [ddr_link_pkg::APB_DATA_W-1:0] pkt_count_r;
  logic [ddr_link_pkg::APB_DATA_W-1:0] status_word;
  logic [ddr_link_pkg::APB_DATA_W-1:0] rdata;
  logic                                access;
  logic                                addr_ok;
  logic                                wr_ctrl;
  logic                                wr_status;
  logic                                wr_count;

  // Access phase of an APB transfer
  assign access    = apb_req_i.psel & apb_req_i.penable;
  assign wr_ctrl   = access & apb_req_i.pwrite & (apb_req_i.paddr == ddr_link_pkg::CTRL_ADDR);
  assign wr_status = access & apb_req_i.pwrite & (apb_req_i.paddr == ddr_link_pkg::STATUS_ADDR);
  assign wr_count  = access & apb_req_i.pwrite
                   & (apb_req_i.paddr == ddr_link_pkg::PKT_COUNT_ADDR);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_r    <= 1'b0;
      flush_r     <= 1'b0;
      overflow_r  <= '0;
      pkt_count_r <= '0;
    end else begin
      flush_r <= wr_ctrl & apb_req_i.pwdata[1];
      if (wr_ctrl) begin
        enable_r <= apb_req_i.pwdata[0];
      end
      // A new overflow wins over a clear in the same cycle
      if (wr_status) begin
        overflow_r <= (overflow_r & ~apb_req_i.pwdata[num_channel_p-1:0]) | overflow_i;
      end else begin
        overflow_r <= overflow_r | overflow_i;
      end
      if (wr_count) begin
        pkt_count_r <= '0;
      end else if (pkt_accept_i) begin
        pkt_count_r <= pkt_count_r + 1'b1;
      end
    end
  end

  always_comb begin
    status_word = '0;
    status_word[num_channel_p-1:0] = overflow_r;
  end

  // Read mux, valid in the access cycle
  always_comb begin
    rdata   = '0;
    addr_ok = 1'b1;
    case (apb_req_i.paddr)
      ddr_link_pkg::CTRL_ADDR:      rdata[0] = enable_r;
      ddr_link_pkg::STATUS_ADDR:    rdata = status_word;
      ddr_link_pkg::PKT_COUNT_ADDR: rdata = pkt_count_r;
      default:                      addr_ok = 1'b0;
    endcase
  end

  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = access & ~addr_ok;
  assign apb_rsp_o.prdata  = rdata;

  assign ctrl_o.enable = enable_r;
  assign ctrl_o.flush  = flush_r;
  assign link_enable_o = enable_r;

endmodule

// File: design/ddr_rx_channel.sv
/* One DDR receive channel clocked by clk_i, no source-synchronous crossing.
   Needs lg_fifo_depth_p >= 1; a beat captured into a full FIFO is dropped */
module ddr_rx_channel #(
  parameter int channel_width_p                 = 8,
  parameter int lg_fifo_depth_p                 = 3,
  parameter int lg_credit_to_token_decimation_p = 1
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  ddr_link_pkg::link_ctrl_t     ctrl_i,
  input  logic [channel_width_p-1:0]   io_data_i,
  input  logic                         io_valid_i,
  output logic                         io_token_r_o,
  output logic [2*channel_width_p-1:0] beat_o,
  output logic                         beat_valid_o,
  input  logic                         beat_yumi_i,
  output logic                         overflow_o
);

  localparam int depth_lp = 1 << lg_fifo_depth_p;
  localparam int dec_w_lp = lg_credit_to_token_decimation_p + 1;
  // 2^lg - 1 held in lg+1 bits
  localparam logic [dec_w_lp-1:0] dec_max_lp = {dec_w_lp{1'b1}} >> 1;

  logic [channel_width_p-1:0]   rise_data_r;
  logic [channel_width_p-1:0]   fall_data_r;
  logic                         rise_valid_r;
  logic [2*channel_width_p-1:0] mem_r [depth_lp];
  logic [lg_fifo_depth_p:0]     wr_ptr_r;
  logic [lg_fifo_depth_p:0]     rd_ptr_r;
  logic [dec_w_lp-1:0]          dec_count_r;
  logic                         dec_done_r;
  logic                         token_r;
  logic                         full;
  logic                         empty;
  logic                         enq;
  logic                         deq;

  // Low half on the rising edge, valid is ignored while disabled
  always_ff @(posedge clk_i) begin
    rise_data_r <= io_data_i;
    if (rst_i | ctrl_i.flush) begin
      rise_valid_r <= 1'b0;
    end else begin
      rise_valid_r <= io_valid_i & ctrl_i.enable;
    end
  end

  // High half on the falling edge of the same cycle
  always_ff @(negedge clk_i) begin
    fall_data_r <= io_data_i;
  end

  // Extra pointer bit tells full from empty
  assign empty = (wr_ptr_r == rd_ptr_r);
  assign full  = (wr_ptr_r[lg_fifo_depth_p] != rd_ptr_r[lg_fifo_depth_p])
               & (wr_ptr_r[lg_fifo_depth_p-1:0] == rd_ptr_r[lg_fifo_depth_p-1:0]);

  assign enq = rise_valid_r & ~full & ~ctrl_i.flush;
  assign deq = beat_yumi_i & ~empty & ~ctrl_i.flush;

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r[lg_fifo_depth_p-1:0]] <= {fall_data_r, rise_data_r};
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i | ctrl_i.flush) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end else begin
      if (enq) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (deq) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
    end
  end

  assign beat_o       = mem_r[rd_ptr_r[lg_fifo_depth_p-1:0]];
  assign beat_valid_o = ~empty;

  // Sender overran its credits
  assign overflow_o = rise_valid_r & full;

  // Count dequeues, one token toggle per decimation group
  always_ff @(posedge clk_i) begin
    if (rst_i | ctrl_i.flush) begin
      dec_count_r <= '0;
      dec_done_r  <= 1'b0;
    end else begin
      dec_done_r <= deq & (dec_count_r == dec_max_lp);
      if (deq) begin
        if (dec_count_r == dec_max_lp) begin
          dec_count_r <= '0;
        end else begin
          dec_count_r <= dec_count_r + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      token_r <= 1'b0;
    end else if (dec_done_r) begin
      token_r <= ~token_r;
    end
  end

  assign io_token_r_o = token_r;

endmodule

// File: design/sipo_assembler.sv
/* Collects els_p joined beats per packet with beat 0 in the low bits.
   Holds one packet on the output and one in collection; els_p must be >= 2 */
module sipo_assembler #(
  parameter int beat_width_p  = 32,
  parameter int els_p         = 2,
  parameter int num_channel_p = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic [beat_width_p-1:0]       beat_i,
  input  logic [num_channel_p-1:0]      beats_valid_i,
  output logic                          beat_yumi_o,
  output logic [beat_width_p*els_p-1:0] data_o,
  output logic                          valid_o,
  input  logic                          yumi_i
);

  localparam int idx_w_lp = $clog2(els_p);
  localparam logic [idx_w_lp-1:0] last_idx_lp = idx_w_lp'(els_p - 1);

  logic [els_p-1:0][beat_width_p-1:0] coll_r;
  logic [els_p-1:0][beat_width_p-1:0] pkt_next;
  logic [els_p-1:0][beat_width_p-1:0] data_r;
  logic [idx_w_lp-1:0]                idx_r;
  logic                               coll_full_r;
  logic                               valid_r;
  logic                               accept;
  logic                               last;
  logic                               out_free;

  // All channels must offer a beat, same as the AND of valids upstream
  assign accept   = (&beats_valid_i) & ~coll_full_r;
  assign last     = accept & (idx_r == last_idx_lp);
  assign out_free = ~valid_r | yumi_i;

  // Completed packet including the beat arriving now
  always_comb begin
    pkt_next = coll_r;
    pkt_next[els_p-1] = beat_i;
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      coll_r[idx_r] <= beat_i;
    end
    if (last & out_free) begin
      data_r <= pkt_next;
    end else if (coll_full_r & out_free) begin
      data_r <= coll_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      idx_r       <= '0;
      coll_full_r <= 1'b0;
      valid_r     <= 1'b0;
    end else begin
      if (last) begin
        idx_r <= '0;
      end else if (accept) begin
        idx_r <= idx_r + 1'b1;
      end
      if (last & out_free) begin
        valid_r <= 1'b1;
      end else if (last) begin
        // Output still busy, park the packet in the collecting word
        coll_full_r <= 1'b1;
      end else if (coll_full_r & out_free) begin
        valid_r     <= 1'b1;
        coll_full_r <= 1'b0;
      end else if (yumi_i) begin
        valid_r <= 1'b0;
      end
    end
  end

  assign beat_yumi_o = accept;
  assign data_o      = data_r;
  assign valid_o     = valid_r;

endmodule

// File: design/ddr_link_downstream.sv
/* DDR link receiver on a single clock; io data is sampled with clk_i itself.
   width_p must be a multiple of 2*channel_width_p*num_channel_p, at least twice */
module ddr_link_downstream #(
  parameter int width_p                         = 64,
  parameter int channel_width_p                 = 8,
  parameter int num_channel_p                   = 2,
  parameter int lg_fifo_depth_p                 = 3,
  parameter int lg_credit_to_token_decimation_p = 1
) (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  ddr_link_pkg::apb_req_t                        apb_req_i,
  output ddr_link_pkg::apb_rsp_t                        apb_rsp_o,
  output logic                                          link_enable_o,
  input  logic [num_channel_p-1:0][channel_width_p-1:0] io_data_i,
  input  logic [num_channel_p-1:0]                      io_valid_i,
  output logic [num_channel_p-1:0]                      io_token_r_o,
  output logic [width_p-1:0]                            data_o,
  output logic                                          valid_o,
  input  logic                                          yumi_i
);

  localparam int ddr_width_lp = 2 * channel_width_p;
  localparam int els_lp       = width_p / (ddr_width_lp * num_channel_p);

  ddr_link_pkg::link_ctrl_t                    ctrl;
  // Channel 0 lands in the low bits of the joined beat
  logic [num_channel_p-1:0][ddr_width_lp-1:0] ch_beat;
  logic [num_channel_p-1:0]                    ch_valid;
  logic [num_channel_p-1:0]                    overflow;
  logic                                        beat_yumi;
  logic                                        pkt_accept;

  assign pkt_accept = valid_o & yumi_i;

  link_ctrl_regs #(
    .num_channel_p(num_channel_p)
  ) regs_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .apb_req_i    (apb_req_i),
    .apb_rsp_o    (apb_rsp_o),
    .overflow_i   (overflow),
    .pkt_accept_i (pkt_accept),
    .ctrl_o       (ctrl),
    .link_enable_o(link_enable_o)
  );

  for (genvar i = 0; i < num_channel_p; i++) begin : g_ch
    ddr_rx_channel #(
      .channel_width_p                (channel_width_p),
      .lg_fifo_depth_p                (lg_fifo_depth_p),
      .lg_credit_to_token_decimation_p(lg_credit_to_token_decimation_p)
    ) channel_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .ctrl_i      (ctrl),
      .io_data_i   (io_data_i[i]),
      .io_valid_i  (io_valid_i[i]),
      .io_token_r_o(io_token_r_o[i]),
      .beat_o      (ch_beat[i]),
      .beat_valid_o(ch_valid[i]),
      .beat_yumi_i (beat_yumi),
      .overflow_o  (overflow[i])
    );
  end

  sipo_assembler #(
    .beat_width_p (ddr_width_lp * num_channel_p),
    .els_p        (els_lp),
    .num_channel_p(num_channel_p)
  ) sipo_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .beat_i       (ch_beat),
    .beats_valid_i(ch_valid),
    .beat_yumi_o  (beat_yumi),
    .data_o       (data_o),
    .valid_o      (valid_o),
    .yumi_i       (yumi_i)
  );

endmodule

// File: dv/tb_ddr_link_downstream.sv
/* Directed tests for the DDR link receiver at its default parameters (64-bit packets).
   DDR data is center aligned: low half launched on the falling edge, high half on the rising */
module tb_ddr_link_downstream;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int width_lp   = 64;
  localparam int cw_lp      = 8;
  localparam int nch_lp     = 2;
  localparam int lg_depth_lp = 3;
  localparam int lg_dec_lp  = 1;
  localparam int bw_lp      = 2 * cw_lp;
  localparam int beat_w_lp  = bw_lp * nch_lp;
  localparam int els_lp     = width_lp / beat_w_lp;
  localparam int depth_lp   = 1 << lg_depth_lp;
  localparam int dec_lp     = 1 << lg_dec_lp;
  localparam int timeout_lp = 500;

  logic                              clk_i;
  logic                              rst_i;
  ddr_link_pkg::apb_req_t            apb_req_i;
  ddr_link_pkg::apb_rsp_t            apb_rsp_o;
  logic                              link_enable_o;
  logic [nch_lp-1:0][cw_lp-1:0]      io_data_i;
  logic [nch_lp-1:0]                 io_valid_i;
  logic [nch_lp-1:0]                 io_token_r_o;
  logic [width_lp-1:0]               data_o;
  logic                              valid_o;
  logic                              yumi_i;

  // Sender and scoreboard state
  logic [nch_lp-1:0][cw_lp-1:0]      hi_pend;
  logic [nch_lp-1:0]                 tok_prev;
  int                                tok_cnt [nch_lp];
  int                                sent [nch_lp];
  logic [31:0]                       rng_state;
  int                                errors;
  int                                checks;
  int                                tests;
  int                                pkt_taken;

  ddr_link_downstream #(
    .width_p                        (width_lp),
    .channel_width_p                (cw_lp),
    .num_channel_p                  (nch_lp),
    .lg_fifo_depth_p                (lg_depth_lp),
    .lg_credit_to_token_decimation_p(lg_dec_lp)
  ) dut_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .apb_req_i    (apb_req_i),
    .apb_rsp_o    (apb_rsp_o),
    .link_enable_o(link_enable_o),
    .io_data_i    (io_data_i),
    .io_valid_i   (io_valid_i),
    .io_token_r_o (io_token_r_o),
    .data_o       (data_o),
    .valid_o      (valid_o),
    .yumi_i       (yumi_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Every token toggle returns dec_lp credits to the sender
  always @(negedge clk_i) begin
    for (int c = 0; c < nch_lp; c++) begin
      if (io_token_r_o[c] !== tok_prev[c]) begin
        tok_cnt[c] = tok_cnt[c] + 1;
      end
      tok_prev[c] = io_token_r_o[c];
    end
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [width_lp-1:0] random_packet();
    logic [31:0] lo_w;
    logic [31:0] hi_w;
    lo_w = next_random();
    hi_w = next_random();
    return {hi_w, lo_w};
  endfunction

  function automatic int credits_left(input int c);
    return depth_lp + dec_lp * tok_cnt[c] - sent[c];
  endfunction

  function automatic bit all_have_credit();
    bit ok;
    ok = 1'b1;
    for (int c = 0; c < nch_lp; c++) begin
      if (credits_left(c) <= 0) ok = 1'b0;
    end
    return ok;
  endfunction

  function automatic bit all_credits_back();
    bit ok;
    ok = 1'b1;
    for (int c = 0; c < nch_lp; c++) begin
      if (credits_left(c) != depth_lp) ok = 1'b0;
    end
    return ok;
  endfunction

  function automatic ddr_link_pkg::apb_rsp_t expected_rsp(input logic err,
                                                          input logic [31:0] data);
    ddr_link_pkg::apb_rsp_t r;
    r.pready  = 1'b1;
    r.pslverr = err;
    r.prdata  = data;
    return r;
  endfunction

  task automatic check_rsp(input ddr_link_pkg::apb_rsp_t got, input ddr_link_pkg::apb_rsp_t exp,
                           input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0d ns: %s: got rdy=%0b err=%0b data=%08h, expected %0b %0b %08h",
               $time, what, got.pready, got.pslverr, got.prdata,
               exp.pready, exp.pslverr, exp.prdata);
    end
  endtask

  task automatic check_packet(input logic [width_lp-1:0] got, input logic [width_lp-1:0] exp,
                              input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0d ns: %s: got %016h, expected %016h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0d ns: %s: got %0b, expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int e0);
    tests++;
    if (errors == e0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - e0);
    end
  endtask

  // Setup phase, access phase, response sampled mid access cycle
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output ddr_link_pkg::apb_rsp_t rsp);
    ddr_link_pkg::apb_req_t req;
    req        = '0;
    req.psel   = 1'b1;
    req.pwrite = wr;
    req.paddr  = addr;
    req.pwdata = wdata;
    @(posedge clk_i);
    apb_req_i <= req;
    req.penable = 1'b1;
    @(posedge clk_i);
    apb_req_i <= req;
    @(negedge clk_i);
    rsp = apb_rsp_o;
    @(posedge clk_i);
    apb_req_i <= '0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata);
    ddr_link_pkg::apb_rsp_t rsp;
    apb_access(1'b1, addr, wdata, rsp);
  endtask

  task automatic read_reg(input logic [7:0] addr, output ddr_link_pkg::apb_rsp_t rsp);
    apb_access(1'b0, addr, '0, rsp);
  endtask

  // Valid and the previous beat's high half on the rising edge, low half on the falling edge
  task automatic drive_cycle(input logic [nch_lp-1:0] vld,
                             input logic [nch_lp-1:0][bw_lp-1:0] beat);
    int c;
    @(posedge clk_i);
    io_valid_i <= vld;
    io_data_i  <= hi_pend;
    @(negedge clk_i);
    for (c = 0; c < nch_lp; c++) begin
      io_data_i[c] <= beat[c][cw_lp-1:0];
      hi_pend[c] = beat[c][bw_lp-1:cw_lp];
    end
  endtask

  // Beat b of channel c sits at bits (b*nch_lp + c)*bw_lp of the packet
  task automatic send_packet(input logic [width_lp-1:0] pkt, input bit need_credit);
    int b;
    int c;
    int t;
    for (b = 0; b < els_lp; b++) begin
      t = 0;
      while (need_credit && !all_have_credit() && t < timeout_lp) begin
        drive_cycle('0, '0);
        t++;
      end
      if (need_credit && !all_have_credit()) begin
        errors++;
        $display("sender ran out of credits at t=%0d ns", $time);
        break;
      end
      drive_cycle('1, pkt[b*beat_w_lp +: beat_w_lp]);
      if (need_credit) begin
        for (c = 0; c < nch_lp; c++) sent[c]++;
      end
    end
    // Launches the last high half
    drive_cycle('0, '0);
  endtask

  task automatic take_packet(output logic [width_lp-1:0] pkt, output bit ok);
    int t;
    t   = 0;
    ok  = 1'b0;
    pkt = '0;
    @(negedge clk_i);
    while (!valid_o && t < timeout_lp) begin
      @(negedge clk_i);
      t++;
    end
    if (!valid_o) begin
      errors++;
      $display("timeout waiting for valid_o at t=%0d ns", $time);
    end else begin
      pkt = data_o;
      ok  = 1'b1;
      @(posedge clk_i);
      yumi_i <= 1'b1;
      @(posedge clk_i);
      yumi_i <= 1'b0;
      pkt_taken++;
    end
  endtask

  // FIFOs and token counters are empty after a flush
  task automatic resync_credits();
    repeat (4) @(posedge clk_i);
    for (int c = 0; c < nch_lp; c++) sent[c] = dec_lp * tok_cnt[c];
  endtask

  task automatic test_reset_regs();
    int e0;
    ddr_link_pkg::apb_rsp_t rsp;
    e0 = errors;
    @(negedge clk_i);
    check_flag(valid_o, 1'b0, "valid_o after reset");
    check_flag(link_enable_o, 1'b0, "link_enable_o after reset");
    read_reg(ddr_link_pkg::CTRL_ADDR, rsp);
    check_rsp(rsp, expected_rsp(1'b0, '0), "CTRL after reset");
    read_reg(ddr_link_pkg::STATUS_ADDR, rsp);
    check_rsp(rsp, expected_rsp(1'b0, '0), "STATUS after reset");
    read_reg(ddr_link_pkg::PKT_COUNT_ADDR, rsp);
    check_rsp(rsp, expected_rsp(1'b0, '0), "PKT_COUNT after reset");
    write_reg(ddr_link_pkg::CTRL_ADDR, 32'h1);
    @(negedge clk_i);
    check_flag(link_enable_o, 1'b1, "link_enable_o after enable");
    read_reg(ddr_link_pkg::CTRL_ADDR, rsp);
    check_rsp(rsp, expected_rsp(1'b0, 32'h1), "CTRL after enable");
    read_reg(8'h0C, rsp);
    check_rsp(rsp, expected_rsp(1'b1, '0), "unmapped address");
    report_test("reset_regs", e0);
  endtask

  task automatic test_assembly_order();
    int e0;
    logic [width_lp-1:0] pkt;
    logic [width_lp-1:0] got;
    bit ok;
    e0  = errors;
    pkt = 64'hF0E1_D2C3_B4A5_9687;
    send_packet(pkt, 1'b1);
    take_packet(got, ok);
    if (ok) check_packet(got, pkt, "known packet");
    report_test("assembly_order", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    int ks;
    int kr;
    int t;
    logic [width_lp-1:0] pkts [20];
    int hold [20];
    logic [width_lp-1:0] got;
    bit ok;
    e0 = errors;
    for (ks = 0; ks < 20; ks++) begin
      pkts[ks] = random_packet();
      hold[ks] = 0;
      if (next_random() % 32'd3 == 0) hold[ks] = 8 + int'(next_random() % 32'd16);
    end
    fork
      begin
        for (ks = 0; ks < 20; ks++) send_packet(pkts[ks], 1'b1);
      end
      begin
        for (kr = 0; kr < 20; kr++) begin
          repeat (hold[kr]) @(posedge clk_i);
          take_packet(got, ok);
          if (ok) check_packet(got, pkts[kr], $sformatf("random packet %0d", kr));
        end
      end
    join
    // All credits come back once the traffic has drained
    t = 0;
    while (!all_credits_back() && t < timeout_lp) begin
      @(negedge clk_i);
      t++;
    end
    if (!all_credits_back()) begin
      errors++;
      $display("credits not returned after traffic at t=%0d ns", $time);
    end
    report_test("backpressure", e0);
  endtask

  task automatic test_overflow();
    int e0;
    int k;
    logic [width_lp-1:0] pkts [8];
    logic [width_lp-1:0] got;
    ddr_link_pkg::apb_rsp_t rsp;
    bit ok;
    e0 = errors;
    // 16 beats against 8 FIFO entries plus 4 assembler beats
    for (k = 0; k < 8; k++) begin
      pkts[k] = random_packet();
      send_packet(pkts[k], 1'b0);
    end
    repeat (2) @(posedge clk_i);
    read_reg(ddr_link_pkg::STATUS_ADDR, rsp);
    check_rsp(rsp, expected_rsp(1'b0, (32'h1 << nch_lp) - 1), "STATUS after overflow");
    write_reg(ddr_link_pkg::STATUS_ADDR, (32'h1 << nch_lp) - 1);
    read_reg(ddr_link_pkg::STATUS_ADDR, rsp);
    check_rsp(rsp, expected_rsp(1'b0, '0), "STATUS after clear");
    // Flush, then drain the first two packets, which the assembler still holds
    write_reg(ddr_link_pkg::CTRL_ADDR, 32'h3);
    for (k = 0; k < 2; k++) begin
      take_packet(got, ok);
      if (ok) check_packet(got, pkts[k], $sformatf("held packet %0d", k));
    end
    resync_credits();
    report_test("overflow", e0);
  endtask

  task automatic test_count_disable_flush();
    int e0;
    int t;
    logic [width_lp-1:0] pkt;
    logic [width_lp-1:0] got;
    ddr_link_pkg::apb_rsp_t rsp;
    bit ok;
    e0 = errors;
    read_reg(ddr_link_pkg::PKT_COUNT_ADDR, rsp);
    check_rsp(rsp, expected_rsp(1'b0, 32'(pkt_taken)), "PKT_COUNT");
    write_reg(ddr_link_pkg::PKT_COUNT_ADDR, '0);
    read_reg(ddr_link_pkg::PKT_COUNT_ADDR, rsp);
    check_rsp(rsp, expected_rsp(1'b0, '0), "PKT_COUNT after clear");
    write_reg(ddr_link_pkg::CTRL_ADDR, 32'h0);
    @(negedge clk_i);
    check_flag(link_enable_o, 1'b0, "link_enable_o after disable");
    send_packet(random_packet(), 1'b0);
    t = 0;
    while (!valid_o && t < 64) begin
      @(negedge clk_i);
      t++;
    end
    check_flag(valid_o, 1'b0, "valid_o while disabled");
    write_reg(ddr_link_pkg::CTRL_ADDR, 32'h3);
    resync_credits();
    check_flag(link_enable_o, 1'b1, "link_enable_o after re-enable");
    pkt = 64'h0123_4567_89AB_CDEF;
    send_packet(pkt, 1'b1);
    take_packet(got, ok);
    if (ok) check_packet(got, pkt, "packet after flush");
    report_test("count_disable_flush", e0);
  endtask

  initial begin
    rst_i      = 1'b1;
    apb_req_i  = '0;
    io_data_i  = '0;
    io_valid_i = '0;
    yumi_i     = 1'b0;
    hi_pend    = '0;
    tok_prev   = '0;
    rng_state  = 32'd68;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    pkt_taken  = 0;
    for (int c = 0; c < nch_lp; c++) begin
      tok_cnt[c] = 0;
      sent[c]    = 0;
    end
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    test_reset_regs();
    test_assembly_order();
    test_backpressure();
    test_overflow();
    test_count_disable_flush();
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
design/ddr_link_pkg.sv
design/link_ctrl_regs.sv
design/ddr_rx_channel.sv
design/sipo_assembler.sv
design/ddr_link_downstream.sv
dv/tb_ddr_link_downstream.sv

// File: run_verilator.sh
#!/bin/sh
# Builds the DDR link testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_ddr_link_downstream \
  -Mdir obj_dir -f filelist.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_ddr_link_downstream)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
